// File: ahb_mmio_subsystem.f
+incdir+common
+incdir+verification
common/ahb_mmio_pkg.sv
hw/ahb_mmio_bridge/ahb_mmio_bridge.sv
hw/mmio_decoder.sv
hw/mmio_regfile.sv
hw/mmio_checksum.sv
hw/ahb_mmio_subsystem.sv
verification/tb_ahb_mmio_subsystem.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ahb_mmio_subsystem
FILELIST = ahb_mmio_subsystem.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/tb_ahb_mmio_tasks.svh
`ifndef TB_AHB_MMIO_TASKS_SVH
`define TB_AHB_MMIO_TASKS_SVH

// Moves to the next cycle once the slave is ready, 1 ns past the clock edge
task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(posedge s_ahb);
    #1;
    while (ahb_rsp.hready !== 1'b1) begin
        cycles++;
        if (cycles > READY_TIMEOUT) begin
            $display("Timed out waiting for hready to go high");
            $display("Simulation failed");
            $fatal(1, "hready timeout");
        end
        @(posedge s_ahb);
        #1;
    end
endtask

// One bus cycle carries the data phase of the last write and a new address phase
task automatic bus_cycle(input logic hsel, input ahb_mmio_pkg::addr_t addr,
                         input ahb_mmio_pkg::htrans_e htrans, input logic hwrite,
                         input ahb_mmio_pkg::hsize_t size, input ahb_mmio_pkg::data_t wdata);
    logic active;
    wait_ready();
    active = (htrans == ahb_mmio_pkg::NONSEQ) || (htrans == ahb_mmio_pkg::SEQ);
    if (wr_pend) begin
        hwdata = wr_data;
        model_write(wr_addr, wr_size, wr_data); // Before the read below, so reads see it
    end else begin
        hwdata = $urandom();
    end
    ahb_req.hsel   = hsel;
    ahb_req.haddr  = addr;
    ahb_req.htrans = htrans;
    ahb_req.hwrite = hwrite;
    ahb_req.hsize  = size;
    rd_pend = hsel && !hwrite && active;
    rd_exp  = rd_pend ? model_read(addr) : '0;
    wr_pend = hsel && hwrite && active;
    wr_addr = addr;
    wr_size = size;
    wr_data = wdata;
endtask

task automatic write_xfer(input ahb_mmio_pkg::addr_t addr, input ahb_mmio_pkg::hsize_t size,
                          input ahb_mmio_pkg::data_t data);
    bus_cycle(1'b1, addr, ahb_mmio_pkg::NONSEQ, 1'b1, size, data);
endtask

task automatic read_xfer(input ahb_mmio_pkg::addr_t addr);
    bus_cycle(1'b1, addr, ahb_mmio_pkg::NONSEQ, 1'b0, 3'd2, '0);
endtask

task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        bus_cycle(1'b0, '0, ahb_mmio_pkg::IDLE, 1'b0, 3'd0, '0);
    end
endtask

`endif

// File: verification/tb_ahb_mmio_subsystem.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module tb_ahb_mmio_subsystem;

    localparam int DEPTH         = `AHB_MMIO_REGFILE_DEPTH;
    localparam int RESET_CYCLES  = 16;
    localparam int READY_TIMEOUT = 50;
    localparam int RF            = `AHB_MMIO_REGION_REGFILE;
    localparam int CS            = `AHB_MMIO_REGION_CHECKSUM;

    logic                    s_ahb;
    logic                    rst_n;
    ahb_mmio_pkg::ahb_req_t  ahb_req;
    ahb_mmio_pkg::data_t     hwdata;
    ahb_mmio_pkg::ahb_rsp_t  ahb_rsp;

    ahb_mmio_pkg::data_t     rf_model [DEPTH];
    ahb_mmio_pkg::data_t     sum_model;
    ahb_mmio_pkg::data_t     count_model;

    // Read in its address phase, and the same read one cycle later in its data phase
    logic                    rd_pend;
    ahb_mmio_pkg::data_t     rd_exp;
    logic                    chk_en = 1'b0;
    ahb_mmio_pkg::data_t     chk_exp;

    logic                    wr_pend;  // Write whose data phase comes next
    ahb_mmio_pkg::addr_t     wr_addr;
    ahb_mmio_pkg::hsize_t    wr_size;
    ahb_mmio_pkg::data_t     wr_data;

    ahb_mmio_subsystem uut (
        .s_ahb   (s_ahb),
        .rst_n   (rst_n),
        .ahb_req (ahb_req),
        .hwdata  (hwdata),
        .ahb_rsp (ahb_rsp)
    );

    initial begin
        s_ahb = 1'b0;
        forever #2 s_ahb = ~s_ahb;
    end

    always @(posedge s_ahb) begin
        chk_en  <= rd_pend;
        chk_exp <= rd_exp;
    end

    a_read_data: assert property (@(posedge s_ahb) disable iff (!rst_n)
        chk_en |-> (ahb_rsp.hrdata == chk_exp))
        else begin
            $display("Fail hrdata: got %08h, expected %08h",
                     $sampled(ahb_rsp.hrdata), $sampled(chk_exp));
            $display("Simulation failed");
            $fatal(1, "Read data mismatch");
        end

    a_ready_okay: assert property (@(posedge s_ahb) disable iff (!rst_n)
        ahb_rsp.hready && (ahb_rsp.hresp == ahb_mmio_pkg::OKAY))
        else begin
            $display("Fail hready/hresp: hready %h, hresp %h",
                     $sampled(ahb_rsp.hready), $sampled(ahb_rsp.hresp));
            $display("Simulation failed");
            $fatal(1, "Bad response");
        end

    function automatic ahb_mmio_pkg::addr_t make_addr(input int region, input int offset);
        return ahb_mmio_pkg::addr_t'((region << `AHB_MMIO_REGION_LSB) | (offset & 'hff));
    endfunction

    // Lanes from the byte offset for 2**size bytes, clipped at the word end
    function automatic ahb_mmio_pkg::data_t lane_mask(input ahb_mmio_pkg::addr_t addr,
                                                      input ahb_mmio_pkg::hsize_t size);
        int first;
        int last;
        ahb_mmio_pkg::data_t mask;
        first = int'(addr[1:0]);
        last  = first + (1 << size) - 1;
        mask  = '0;
        for (int b = first; b <= last && b < 4; b++) begin
            mask[b*8 +: 8] = 8'hff;
        end
        return mask;
    endfunction

    function automatic ahb_mmio_pkg::data_t model_read(input ahb_mmio_pkg::addr_t addr);
        int region;
        int word;
        region = int'(addr[`AHB_MMIO_REGION_MSB:`AHB_MMIO_REGION_LSB]);
        word   = int'(addr[`AHB_MMIO_REGION_LSB-1:2]);
        if (region == RF)
            return rf_model[word % DEPTH];
        if (region == CS && word == 1)
            return sum_model;
        if (region == CS && word == 3)
            return count_model;
        return '0;
    endfunction

    function automatic void model_write(input ahb_mmio_pkg::addr_t addr,
                                        input ahb_mmio_pkg::hsize_t size,
                                        input ahb_mmio_pkg::data_t data);
        int region;
        int word;
        ahb_mmio_pkg::data_t m;
        region = int'(addr[`AHB_MMIO_REGION_MSB:`AHB_MMIO_REGION_LSB]);
        word   = int'(addr[`AHB_MMIO_REGION_LSB-1:2]);
        m      = lane_mask(addr, size);
        if (region == RF) begin
            rf_model[word % DEPTH] = (rf_model[word % DEPTH] & ~m) | (data & m);
        end else if (region == CS && word == 0) begin
            sum_model   = sum_model + (data & m);
            count_model = count_model + 1;
        end else if (region == CS && word == 2) begin
            sum_model   = '0;
            count_model = '0;
        end
    endfunction

    `include "tb_ahb_mmio_tasks.svh"

    initial begin
        ahb_mmio_pkg::addr_t   addr;
        ahb_mmio_pkg::htrans_e trans;
        int                    region;
        void'($urandom(79989));
        rst_n   = 1'b0;
        ahb_req = '0;
        hwdata  = '0;
        rd_pend = 1'b0;
        rd_exp  = '0;
        wr_pend = 1'b0;
        wr_addr = '0;
        wr_size = '0;
        wr_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            rf_model[i] = '0;
        end
        sum_model   = '0;
        count_model = '0;
        repeat (RESET_CYCLES) @(posedge s_ahb);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < DEPTH; i++) begin
            read_xfer(make_addr(RF, i * 4));
        end
        read_xfer(make_addr(CS, 'h4));
        read_xfer(make_addr(CS, 'hc));

        // Full words through aliased offsets that wrap on the depth
        for (int i = 0; i < DEPTH; i++) begin
            write_xfer(make_addr(RF, (i + DEPTH * $urandom_range(0, 7)) * 4), 3'd2, $urandom());
        end
        for (int i = 0; i < DEPTH; i++) begin
            read_xfer(make_addr(RF, (i + DEPTH * $urandom_range(0, 7)) * 4));
        end

        for (int n = 0; n < 40; n++) begin
            addr = make_addr(RF, $urandom_range(0, 255));
            write_xfer(addr, ahb_mmio_pkg::hsize_t'($urandom_range(0, 1)), $urandom());
            read_xfer(addr);  // Meets the data phase of the write
        end

        for (int n = 0; n < 12; n++) begin
            write_xfer(make_addr(CS, $urandom_range(0, 3)),
                       ahb_mmio_pkg::hsize_t'($urandom_range(0, 2)), $urandom());
            read_xfer(make_addr(CS, (n % 2 == 0) ? 'h4 : 'hc));
            if (n % 4 == 3) begin
                write_xfer(make_addr(CS, 'h8), 3'd2, $urandom());
                read_xfer(make_addr(CS, 'hc));
            end
        end

        // None of these may touch model state
        for (int n = 0; n < 20; n++) begin
            trans = ($urandom_range(0, 1) == 0) ? ahb_mmio_pkg::IDLE : ahb_mmio_pkg::BUSY;
            bus_cycle(1'b1, make_addr(RF, $urandom_range(0, 255)), trans, 1'b1, 3'd2, $urandom());
            bus_cycle(1'b0, make_addr(CS, 0), ahb_mmio_pkg::NONSEQ, 1'b1, 3'd2, $urandom());
            region = $urandom_range(2, 15);
            write_xfer(make_addr(region, $urandom_range(0, 255)), 3'd2, $urandom());
            read_xfer(make_addr(region, $urandom_range(0, 255)));
        end
        for (int i = 0; i < DEPTH; i++) begin
            read_xfer(make_addr(RF, i * 4));
        end
        read_xfer(make_addr(CS, 'h4));
        read_xfer(make_addr(CS, 'hc));

        for (int n = 0; n < 300; n++) begin
            case ($urandom_range(0, 4))
                0, 1:    region = RF;
                2, 3:    region = CS;
                default: region = $urandom_range(2, 15);
            endcase
            addr  = make_addr(region, (region == CS) ? $urandom_range(0, 15) : $urandom_range(0, 255));
            trans = ahb_mmio_pkg::htrans_e'($urandom_range(0, 3));
            bus_cycle($urandom_range(0, 7) != 0, addr, trans, $urandom_range(0, 1) == 1,
                      ahb_mmio_pkg::hsize_t'($urandom_range(0, 2)), $urandom());
        end
        idle_cycles(4);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/ahb_mmio_subsystem.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module ahb_mmio_subsystem (
    input  wire                       s_ahb,
    input  wire                       rst_n,
    input  ahb_mmio_pkg::ahb_req_t    ahb_req,
    input  ahb_mmio_pkg::data_t       hwdata,
    output ahb_mmio_pkg::ahb_rsp_t    ahb_rsp
);

    ahb_mmio_pkg::mmio_req_t   mmio_req;
    ahb_mmio_pkg::mmio_rsp_t   mmio_rsp;

    // Per-peripheral views after address decoding
    ahb_mmio_pkg::mmio_req_t   regfile_req;
    ahb_mmio_pkg::mmio_rsp_t   regfile_rsp;
    ahb_mmio_pkg::mmio_req_t   checksum_req;
    ahb_mmio_pkg::mmio_rsp_t   checksum_rsp;

    ahb_mmio_bridge u_bridge (
        .s_ahb    (s_ahb),
        .rst_n    (rst_n),
        .ahb_req  (ahb_req),
        .hwdata   (hwdata),
        .ahb_rsp  (ahb_rsp),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp)
    );

    mmio_decoder u_decoder (
        .s_ahb        (s_ahb),
        .rst_n        (rst_n),
        .mmio_req     (mmio_req),
        .regfile_req  (regfile_req),
        .regfile_rsp  (regfile_rsp),
        .checksum_req (checksum_req),
        .checksum_rsp (checksum_rsp),
        .mmio_rsp     (mmio_rsp)
    );

    mmio_regfile #(
        .DEPTH (`AHB_MMIO_REGFILE_DEPTH)
    ) u_regfile (
        .s_ahb    (s_ahb),
        .rst_n    (rst_n),
        .mmio_req (regfile_req),
        .mmio_rsp (regfile_rsp)
    );

    mmio_checksum u_checksum (
        .s_ahb    (s_ahb),
        .rst_n    (rst_n),
        .mmio_req (checksum_req),
        .mmio_rsp (checksum_rsp)
    );

endmodule

`default_nettype wire

// File: hw/mmio_checksum.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module mmio_checksum (
    input  wire                       s_ahb,
    input  wire                       rst_n,
    input  ahb_mmio_pkg::mmio_req_t   mmio_req,
    output ahb_mmio_pkg::mmio_rsp_t   mmio_rsp
);

    localparam int WORD_LSB = $clog2(`AHB_MMIO_DATA_W / 8);
    localparam int OFF_W    = `AHB_MMIO_REGION_LSB - WORD_LSB;

    localparam logic [OFF_W-1:0] REG_DATA  = OFF_W'(0);
    localparam logic [OFF_W-1:0] REG_SUM   = OFF_W'(1);
    localparam logic [OFF_W-1:0] REG_CLEAR = OFF_W'(2);
    localparam logic [OFF_W-1:0] REG_COUNT = OFF_W'(3);

    logic [OFF_W-1:0]      wr_word;
    logic [OFF_W-1:0]      rd_word;
    ahb_mmio_pkg::data_t   sum_q;
    ahb_mmio_pkg::data_t   count_q;
    ahb_mmio_pkg::data_t   sum_d;
    ahb_mmio_pkg::data_t   count_d;
    ahb_mmio_pkg::data_t   rd_data_q;

    assign wr_word = mmio_req.wr_addr[`AHB_MMIO_REGION_LSB-1:WORD_LSB];
    assign rd_word = mmio_req.rd_addr[`AHB_MMIO_REGION_LSB-1:WORD_LSB];

    always_comb begin
        sum_d   = sum_q;
        count_d = count_q;
        if (mmio_req.wr_en && wr_word == REG_DATA) begin
            // Disabled byte lanes count as zero
            sum_d   = sum_q + (mmio_req.wr_data & ahb_mmio_pkg::byte_mask(mmio_req.wr_byteen));
            count_d = count_q + 'd1;
        end else if (mmio_req.wr_en && wr_word == REG_CLEAR) begin
            sum_d   = '0;
            count_d = '0;
        end
    end

    always_ff @(posedge s_ahb) begin
        if (!rst_n) begin
            sum_q   <= '0;
            count_q <= '0;
        end else begin
            sum_q   <= sum_d;
            count_q <= count_d;
        end
    end

    // Reading from the next-state values makes reads write-first
    always_ff @(posedge s_ahb) begin
        if (mmio_req.rd_en) begin
            case (rd_word)
                REG_SUM:   rd_data_q <= sum_d;
                REG_COUNT: rd_data_q <= count_d;
                default:   rd_data_q <= '0;   // DATA and CLEAR are write-only
            endcase
        end
    end

    assign mmio_rsp.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: hw/mmio_regfile.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module mmio_regfile #(
    parameter int DEPTH = `AHB_MMIO_REGFILE_DEPTH
) (
    input  wire                       s_ahb,
    input  wire                       rst_n,
    input  ahb_mmio_pkg::mmio_req_t   mmio_req,
    output ahb_mmio_pkg::mmio_rsp_t   mmio_rsp
);

    localparam int WORD_LSB = $clog2(`AHB_MMIO_DATA_W / 8);
    localparam int IDX_W    = $clog2(DEPTH);

    ahb_mmio_pkg::data_t   mem [DEPTH];
    logic [IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]      rd_idx;
    ahb_mmio_pkg::data_t   wr_mask;
    ahb_mmio_pkg::data_t   rd_mask;
    ahb_mmio_pkg::data_t   rd_data_q;

    // Higher offset bits are ignored so offsets wrap modulo the depth
    assign wr_idx  = mmio_req.wr_addr[WORD_LSB +: IDX_W];
    assign rd_idx  = mmio_req.rd_addr[WORD_LSB +: IDX_W];
    assign wr_mask = ahb_mmio_pkg::byte_mask(mmio_req.wr_byteen);

    assign rd_mask = (mmio_req.wr_en && wr_idx == rd_idx) ? wr_mask : '0;

    always_ff @(posedge s_ahb) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mmio_req.wr_en) begin
            mem[wr_idx] <= (mem[wr_idx] & ~wr_mask) | (mmio_req.wr_data & wr_mask);
        end
    end

    // Bytes written in the same cycle win over the stored word
    always_ff @(posedge s_ahb) begin
        if (mmio_req.rd_en) begin
            rd_data_q <= (mem[rd_idx] & ~rd_mask) | (mmio_req.wr_data & rd_mask);
        end
    end

    assign mmio_rsp.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: hw/mmio_decoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module mmio_decoder (
    input  wire                       s_ahb,
    input  wire                       rst_n,
    input  ahb_mmio_pkg::mmio_req_t   mmio_req,
    output ahb_mmio_pkg::mmio_req_t   regfile_req,
    input  ahb_mmio_pkg::mmio_rsp_t   regfile_rsp,
    output ahb_mmio_pkg::mmio_req_t   checksum_req,
    input  ahb_mmio_pkg::mmio_rsp_t   checksum_rsp,
    output ahb_mmio_pkg::mmio_rsp_t   mmio_rsp
);

    localparam int REGION_W = `AHB_MMIO_REGION_MSB - `AHB_MMIO_REGION_LSB + 1;
    localparam ahb_mmio_pkg::addr_t OFFSET_MASK =
        ahb_mmio_pkg::addr_t'((1 << `AHB_MMIO_REGION_LSB) - 1);

    logic rd_sel_regfile_q;
    logic rd_sel_checksum_q;

    // Keeps only the accesses aimed at one region and strips the region bits
    function automatic ahb_mmio_pkg::mmio_req_t route(
        input ahb_mmio_pkg::mmio_req_t req,
        input logic [REGION_W-1:0]     region
    );
        ahb_mmio_pkg::mmio_req_t sub;
        sub         = req;
        sub.wr_en   = req.wr_en
            && (req.wr_addr[`AHB_MMIO_REGION_MSB:`AHB_MMIO_REGION_LSB] == region);
        sub.rd_en   = req.rd_en
            && (req.rd_addr[`AHB_MMIO_REGION_MSB:`AHB_MMIO_REGION_LSB] == region);
        sub.wr_addr = req.wr_addr & OFFSET_MASK;
        sub.rd_addr = req.rd_addr & OFFSET_MASK;
        return sub;
    endfunction

    assign regfile_req  = route(mmio_req, REGION_W'(`AHB_MMIO_REGION_REGFILE));
    assign checksum_req = route(mmio_req, REGION_W'(`AHB_MMIO_REGION_CHECKSUM));

    always_ff @(posedge s_ahb) begin
        if (!rst_n) begin
            rd_sel_regfile_q  <= 1'b0;
            rd_sel_checksum_q <= 1'b0;
        end else begin
            rd_sel_regfile_q  <= regfile_req.rd_en;
            rd_sel_checksum_q <= checksum_req.rd_en;
        end
    end

    // Unmapped reads fall through to zero
    assign mmio_rsp.rd_data = rd_sel_regfile_q  ? regfile_rsp.rd_data :
                              rd_sel_checksum_q ? checksum_rsp.rd_data : '0;

endmodule

`default_nettype wire

// File: hw/ahb_mmio_bridge/ahb_mmio_bridge.sv
`default_nettype none
`timescale 1ns/100ps

`include "ahb_mmio_config.svh"

module ahb_mmio_bridge (
    input  wire                       s_ahb,
    input  wire                       rst_n,
    input  ahb_mmio_pkg::ahb_req_t    ahb_req,
    input  ahb_mmio_pkg::data_t       hwdata,
    output ahb_mmio_pkg::ahb_rsp_t    ahb_rsp,
    output ahb_mmio_pkg::mmio_req_t   mmio_req,
    input  ahb_mmio_pkg::mmio_rsp_t   mmio_rsp
);

    localparam int NBYTES     = `AHB_MMIO_DATA_W / 8;
    localparam int BYTE_OFF_W = $clog2(NBYTES);

    logic                      active;
    logic                      rd_issue;
    logic                      wr_issue;
    logic [BYTE_OFF_W-1:0]     byte_off;
    ahb_mmio_pkg::byteen_t     byteen_d;

    logic                      wr_en_q;
    ahb_mmio_pkg::addr_t       wr_addr_q;
    ahb_mmio_pkg::byteen_t     byteen_q;

    logic                      same_rf_word;

    assign active   = ahb_req.htrans inside {ahb_mmio_pkg::NONSEQ, ahb_mmio_pkg::SEQ};
    assign rd_issue = ahb_req.hsel && !ahb_req.hwrite && active;
    assign wr_issue = ahb_req.hsel && ahb_req.hwrite && active;
    assign byte_off = ahb_req.haddr[BYTE_OFF_W-1:0];

    // Lanes from the byte offset up to offset plus 2**hsize, clipped at the word end
    always_comb begin
        byteen_d = '0;
        for (int j = 0; j < NBYTES; j++) begin
            byteen_d[j] = (j >= int'(byte_off)) && (j < int'(byte_off) + (1 << ahb_req.hsize));
        end
    end

    always_ff @(posedge s_ahb) begin
        if (!rst_n) begin
            wr_en_q  <= 1'b0;
            byteen_q <= '0;
        end else begin
            wr_en_q  <= wr_issue;
            byteen_q <= wr_issue ? byteen_d : '0;
        end
    end

    always_ff @(posedge s_ahb) begin
        wr_addr_q <= ahb_req.haddr;
    end

    // Writes go out in the data phase, reads straight from the address phase
    always_comb begin
        mmio_req.wr_en     = wr_en_q;
        mmio_req.wr_addr   = wr_addr_q;
        mmio_req.wr_data   = hwdata;
        mmio_req.wr_byteen = byteen_q;
        mmio_req.rd_en     = rd_issue;
        mmio_req.rd_addr   = ahb_req.haddr;
    end

    assign ahb_rsp.hrdata = mmio_rsp.rd_data;
    assign ahb_rsp.hready = 1'b1;                   // Zero wait states
    assign ahb_rsp.hresp  = ahb_mmio_pkg::OKAY;

    // A read meeting a write to the same register file word in one cycle
    assign same_rf_word = mmio_req.wr_en && mmio_req.rd_en
        && (mmio_req.wr_addr[`AHB_MMIO_ADDR_W-1:BYTE_OFF_W]
            == mmio_req.rd_addr[`AHB_MMIO_ADDR_W-1:BYTE_OFF_W])
        && (mmio_req.rd_addr[`AHB_MMIO_REGION_MSB:`AHB_MMIO_REGION_LSB]
            == (`AHB_MMIO_REGION_MSB - `AHB_MMIO_REGION_LSB + 1)'(`AHB_MMIO_REGION_REGFILE));

    a_hsize_fits_word: assert property (
        @(posedge s_ahb) disable iff (!rst_n)
        (ahb_req.hsel && active) |-> (int'(ahb_req.hsize) <= BYTE_OFF_W)
    );

    // The peripheral must hand back the freshly written bytes one cycle later
    a_write_first: assert property (
        @(posedge s_ahb) disable iff (!rst_n)
        same_rf_word |=>
            ((ahb_rsp.hrdata & ahb_mmio_pkg::byte_mask($past(mmio_req.wr_byteen)))
             == ($past(mmio_req.wr_data) & ahb_mmio_pkg::byte_mask($past(mmio_req.wr_byteen))))
    );

endmodule

`default_nettype wire

// File: common/ahb_mmio_pkg.sv
`default_nettype none

`include "ahb_mmio_config.svh"

package ahb_mmio_pkg;

    typedef logic [`AHB_MMIO_ADDR_W-1:0]   addr_t;
    typedef logic [`AHB_MMIO_DATA_W-1:0]   data_t;
    typedef logic [`AHB_MMIO_DATA_W/8-1:0] byteen_t;
    typedef logic [2:0]                    hsize_t;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // Address phase of an AHB-Lite transfer
    typedef struct packed {
        logic    hsel;
        addr_t   haddr;
        htrans_e htrans;
        logic    hwrite;
        hsize_t  hsize;
    } ahb_req_t;

    typedef struct packed {
        data_t  hrdata;
        logic   hready;
        hresp_e hresp;
    } ahb_rsp_t;

    // MMIO request, the write and read halves are independent
    typedef struct packed {
        logic    wr_en;
        addr_t   wr_addr;
        data_t   wr_data;
        byteen_t wr_byteen;
        logic    rd_en;
        addr_t   rd_addr;
    } mmio_req_t;

    typedef struct packed {
        data_t rd_data; // Valid in the cycle after rd_en
    } mmio_rsp_t;

    // Widens each byte enable to a full byte of mask
    function automatic data_t byte_mask(input byteen_t byteen);
        data_t mask;
        for (int b = 0; b < $bits(byteen_t); b++) begin
            mask[b*8 +: 8] = {8{byteen[b]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: common/ahb_mmio_config.svh
`ifndef AHB_MMIO_CONFIG_SVH
`define AHB_MMIO_CONFIG_SVH

// Bus widths
`define AHB_MMIO_ADDR_W 32
`define AHB_MMIO_DATA_W 32

// Words held by the scratch register file, a power of two
`define AHB_MMIO_REGFILE_DEPTH 8

// Address bits that select a peripheral region
`define AHB_MMIO_REGION_MSB 11
`define AHB_MMIO_REGION_LSB 8

// Region numbers of the peripherals
`define AHB_MMIO_REGION_REGFILE  0
`define AHB_MMIO_REGION_CHECKSUM 1

`endif
